//--- hw/balance_pkg.sv
// shared widths, types and gains for the balance controller; import with balance_pkg::*
package balance_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int PTCH_W   = 16;  // raw pitch from the inertial unit
  localparam int LD_W     = 12;  // load-cell difference
  localparam int ERR_W    = 10;  // saturated pitch error
  localparam int INTEG_W  = 18;  // integrator accumulator
  localparam int TORQUE_W = 16;  // torque and shaped duty
  localparam int SPD_W    = 11;  // unsigned motor speed

  ////////////////////
  // types
  ////////////////////
  typedef logic signed [PTCH_W-1:0]   ptch_t;     // measured pitch
  typedef logic signed [LD_W-1:0]     ld_diff_t;  // left load minus right load
  typedef logic signed [ERR_W-1:0]    ptch_err_t; // pitch clipped to 10 bits
  typedef logic signed [INTEG_W-1:0]  integ_t;    // I accumulator
  typedef logic signed [TORQUE_W-1:0] torque_t;   // torque, shaped torque
  typedef logic        [SPD_W-1:0]    spd_t;      // speed magnitude, no sign

  ////////////////////
  // control constants
  ////////////////////
  localparam logic signed [5:0] P_COEFF = 6'sd14;         // proportional gain
  localparam logic signed [5:0] D_COEFF = 6'sd20;         // derivative gain

  // below this torque magnitude the gain multiplier is used instead of min duty
  localparam logic [TORQUE_W-1:0] LOW_TORQUE_BAND = 16'd70;
  localparam logic signed [5:0]   GAIN_MULTIPLIER = 6'sd15; // 1 + MIN_DUTY/band
  localparam torque_t             MIN_DUTY        = 16'sd980; // stiffens the motor

  localparam spd_t SPD_MAX       = 11'h7FF;   // saturated speed
  localparam spd_t OVR_SPD_LIMIT = 11'd1536;  // warn the rider above this

endpackage

//--- hw/motor_cmd_if.sv
// bundle of both wheel commands, driven by the wheel drive and read by the top level
`timescale 1ns/1ns

interface motor_cmd_if
  import balance_pkg::*;
();

  spd_t lft_spd;   // left motor speed
  logic lft_rev;   // 1 = run left motor in reverse
  spd_t rght_spd;  // right motor speed
  logic rght_rev;  // 1 = run right motor in reverse

  // producer side
  modport drv (output lft_spd, lft_rev, rght_spd, rght_rev);
  // consumer side
  modport mon (input lft_spd, lft_rev, rght_spd, rght_rev);

endinterface

//--- hw/ptch_pid.sv
// pitch PID stage: saturates pitch, forms registered P and D terms and the integrator
`timescale 1ns/1ns

module ptch_pid
  import balance_pkg::*;
#(
  parameter bit fast_sim = 1'b0  // 1 = integral term 16x stronger, for short sims
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    vld,        // new inertial reading this cycle
  input  ptch_t   ptch,       // measured pitch
  input  logic    rider_off,  // no weight on the load cells
  input  logic    pwr_up,     // I term only counts while powered
  output torque_t pid_cntrl   // summed P + I + D command
);

  localparam ptch_err_t ERR_MOST_NEG = 10'sh200;
  localparam ptch_err_t ERR_MOST_POS = 10'sh1FF;
  localparam logic signed [6:0] DIFF_MOST_NEG = 7'sh40;
  localparam logic signed [6:0] DIFF_MOST_POS = 7'sh3F;

  ptch_err_t ptch_err;          // saturated pitch error
  integ_t    err_ext;           // error sign-extended to integrator width
  integ_t    integ;             // I accumulator
  integ_t    integ_nxt;         // candidate next integrator
  logic      integ_ovfl;        // add would wrap, so freeze
  ptch_err_t err_d1;            // error one reading back
  ptch_err_t err_d2;            // error two readings back
  ptch_err_t d_diff;            // current minus two readings back
  logic signed [6:0]  d_sat;    // diff clipped to 7 bits
  logic signed [14:0] p_term;   // 6b gain x 10b error, registered
  logic signed [12:0] d_term;   // 6b gain x 7b diff, registered
  torque_t   i_term;            // integral contribution before gating

  ////////////////////
  // pitch saturation
  ////////////////////
  // upper 7 bits all equal the sign means it fits in 10 bits
  always_comb begin
    if (ptch[15]) begin
      ptch_err = (&ptch[15:9]) ? ptch[9:0] : ERR_MOST_NEG;  // too negative -> 0x200
    end else begin
      ptch_err = (|ptch[15:9]) ? ERR_MOST_POS : ptch[9:0];  // too positive -> 0x1FF
    end
  end

  ////////////////////
  // P term
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_term <= '0;
    end else begin
      p_term <= P_COEFF * ptch_err;  // max 14*512, fits in 15 bits signed
    end
  end

  ////////////////////
  // integrator
  ////////////////////
  assign err_ext   = {{(INTEG_W-ERR_W){ptch_err[ERR_W-1]}}, ptch_err};
  assign integ_nxt = integ + err_ext;

  // same-sign operands giving an opposite-sign sum is a wrap
  assign integ_ovfl = (integ[INTEG_W-1] == err_ext[INTEG_W-1]) &&
                      (integ_nxt[INTEG_W-1] != integ[INTEG_W-1]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ <= '0;
    end else if (rider_off) begin
      integ <= '0;                        // rider stepped off, forget history
    end else if (vld && !integ_ovfl) begin
      integ <= integ_nxt;                 // otherwise hold (freeze on overflow)
    end
  end

  // normal: bits 17:6 sign-extended; fast_sim: bits 17:2
  assign i_term = fast_sim ? integ[17:2]
                           : {{4{integ[17]}}, integ[17:6]};

  ////////////////////
  // D term
  ////////////////////
  // two-deep history of the error, advancing per reading
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_d1 <= '0;
      err_d2 <= '0;
    end else if (vld) begin
      err_d1 <= ptch_err;
      err_d2 <= err_d1;
    end
  end

  assign d_diff = ptch_err - err_d2;  // kept at 10 bits, wraps like the error

  always_comb begin
    if (d_diff[9]) begin
      d_sat = (&d_diff[9:6]) ? d_diff[6:0] : DIFF_MOST_NEG;
    end else begin
      d_sat = (|d_diff[9:6]) ? DIFF_MOST_POS : d_diff[6:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_term <= '0;
    end else begin
      d_term <= D_COEFF * d_sat;  // 20 * +-64 fits 13 bits
    end
  end

  ////////////////////
  // sum
  ////////////////////
  // all three sign-extended to 16 bits, I gated by power
  assign pid_cntrl = {p_term[14], p_term} +
                     {{3{d_term[12]}}, d_term} +
                     (pwr_up ? i_term : '0);

endmodule

//--- hw/torque_shaper.sv
// one wheel's torque to duty shaping with speed saturation; instantiated per wheel
`timescale 1ns/1ns

module torque_shaper
  import balance_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  torque_t torque,  // requested wheel torque
  input  logic    pwr_up,  // speed forced to 0 when low
  output spd_t    spd,     // speed magnitude, saturated
  output logic    rev      // 1 = reverse
);

  logic [TORQUE_W-1:0] trq_mag;     // |torque|
  torque_t             trq_duty;    // torque pushed out by MIN_DUTY
  torque_t             trq_gain;    // torque scaled for the low band
  torque_t             shaped_nxt;  // selected shaping
  torque_t             shaped;      // registered shaped torque
  logic [TORQUE_W-1:0] shaped_mag;  // |shaped|
  spd_t                spd_sat;     // magnitude clipped to 11 bits

  ////////////////////
  // shaping
  ////////////////////
  assign trq_mag = torque[TORQUE_W-1] ? -torque : torque;

  // add MIN_DUTY with the torque's own sign
  assign trq_duty = torque[TORQUE_W-1] ? (torque - MIN_DUTY)
                                       : (torque + MIN_DUTY);

  assign trq_gain = GAIN_MULTIPLIER * torque;  // low 16 bits kept

  // small torques get the gain, larger ones the min duty offset
  assign shaped_nxt = (trq_mag >= LOW_TORQUE_BAND) ? trq_duty : trq_gain;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shaped <= '0;
    end else begin
      shaped <= shaped_nxt;
    end
  end

  ////////////////////
  // output
  ////////////////////
  assign rev = shaped[TORQUE_W-1];  // sign gives direction

  assign shaped_mag = shaped[TORQUE_W-1] ? -shaped : shaped;

  // anything in bits 15:11 means beyond 2047
  assign spd_sat = (|shaped_mag[TORQUE_W-1:SPD_W]) ? SPD_MAX
                                                   : shaped_mag[SPD_W-1:0];

  assign spd = pwr_up ? spd_sat : '0;  // unpowered motors stay still

endmodule

//--- hw/wheel_drive.sv
// steering mix of the PID command into two wheel shapers plus the overspeed warning
`timescale 1ns/1ns

module wheel_drive
  import balance_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  torque_t     pid_cntrl,     // balance command from the PID
  input  ld_diff_t    ld_cell_diff,  // left minus right load
  input  logic        en_steer,      // rider is steering
  input  logic        pwr_up,
  output logic        ovr_spd,       // to the piezo warning
  motor_cmd_if.drv    mc             // both wheels' speed and direction
);

  ld_diff_t ld_div8;    // load difference / 8
  torque_t  steer_ofs;  // same, at torque width
  torque_t  lft_trq;
  torque_t  rght_trq;

  ////////////////////
  // steering mix
  ////////////////////
  assign ld_div8   = ld_cell_diff >>> 3;  // keeps the sign
  assign steer_ofs = {{(TORQUE_W-LD_W){ld_div8[LD_W-1]}}, ld_div8};

  // heavier on the left slows the left wheel and speeds the right
  assign lft_trq  = en_steer ? (pid_cntrl - steer_ofs) : pid_cntrl;
  assign rght_trq = en_steer ? (pid_cntrl + steer_ofs) : pid_cntrl;

  torque_shaper u_lft_shaper (
    .clk    (clk),
    .rst_n  (rst_n),
    .torque (lft_trq),
    .pwr_up (pwr_up),
    .spd    (mc.lft_spd),
    .rev    (mc.lft_rev)
  );

  torque_shaper u_rght_shaper (
    .clk    (clk),
    .rst_n  (rst_n),
    .torque (rght_trq),
    .pwr_up (pwr_up),
    .spd    (mc.rght_spd),
    .rev    (mc.rght_rev)
  );

  // saturated speed 2047 always trips this
  assign ovr_spd = (mc.lft_spd > OVR_SPD_LIMIT) || (mc.rght_spd > OVR_SPD_LIMIT);

endmodule

//--- hw/balance_cntrl.sv
// balance controller top level: PID feeding the wheel drive, motor commands on plain ports
`timescale 1ns/1ns

module balance_cntrl
  import balance_pkg::*;
#(
  parameter bit fast_sim = 1'b0  // speeds up the integral term for simulation
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     vld,           // one pulse per inertial reading
  input  ptch_t    ptch,          // measured pitch
  input  ld_diff_t ld_cell_diff,  // left minus right load
  input  logic     rider_off,
  input  logic     en_steer,
  input  logic     pwr_up,
  output spd_t     lft_spd,
  output logic     lft_rev,
  output spd_t     rght_spd,
  output logic     rght_rev,
  output logic     ovr_spd
);

  torque_t pid_cntrl;  // PID command into the wheel drive

  motor_cmd_if mc ();

  ptch_pid #(.fast_sim(fast_sim)) u_ptch_pid (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (vld),
    .ptch      (ptch),
    .rider_off (rider_off),
    .pwr_up    (pwr_up),
    .pid_cntrl (pid_cntrl)
  );

  wheel_drive u_wheel_drive (
    .clk          (clk),
    .rst_n        (rst_n),
    .pid_cntrl    (pid_cntrl),
    .ld_cell_diff (ld_cell_diff),
    .en_steer     (en_steer),
    .pwr_up       (pwr_up),
    .ovr_spd      (ovr_spd),
    .mc           (mc.drv)
  );

  assign lft_spd  = mc.lft_spd;  // unpack to plain ports
  assign lft_rev  = mc.lft_rev;
  assign rght_spd = mc.rght_spd;
  assign rght_rev = mc.rght_rev;

endmodule

//--- tb/tb_clk_gen.sv
// testbench clock and reset source; instantiate once in the testbench top
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period    = 8,   // ns
  parameter int rst_cycles = 10  // cycles rst_n stays low
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;  // release away from the active edge
  end

  always #(period/2) clk = ~clk;

endmodule

//--- tb/balance_chk.sv
// concurrent assertions on the controller outputs; attached to balance_cntrl by bind
`timescale 1ns/1ns

module balance_chk
  import balance_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic pwr_up,
  input spd_t lft_spd,
  input logic lft_rev,
  input spd_t rght_spd,
  input logic rght_rev,
  input logic ovr_spd
);

  // unpowered motors must not turn
  a_pwr_gate: assert property (@(posedge clk) disable iff (!rst_n)
    !pwr_up |-> (lft_spd == '0 && rght_spd == '0))
    else $error("speed nonzero while pwr_up is low");

  // warning rises when either wheel runs above 1536
  a_ovr_spd: assert property (@(posedge clk) disable iff (!rst_n)
    ovr_spd == ((lft_spd > 11'd1536) || (rght_spd > 11'd1536)))
    else $error("ovr_spd disagrees with the speed compare");

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({lft_spd, lft_rev, rght_spd, rght_rev, ovr_spd}))
    else $error("unknown value on a controller output");

endmodule

bind balance_cntrl balance_chk u_balance_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .pwr_up   (pwr_up),
  .lft_spd  (lft_spd),
  .lft_rev  (lft_rev),
  .rght_spd (rght_spd),
  .rght_rev (rght_rev),
  .ovr_spd  (ovr_spd)
);

//--- tb/balance_tb.sv
// testbench top: random stimulus into the balance controller, checked against a cycle model
`timescale 1ns/1ns

module balance_tb
  import balance_pkg::*;
;

  logic clk, rst_n;
  logic vld, rider_off, en_steer, pwr_up;
  ptch_t ptch;
  ld_diff_t ld_cell_diff;
  spd_t lft_spd, rght_spd;
  logic lft_rev, rght_rev, ovr_spd;

  int n_checks = 0;
  int n_errors = 0;

  // model registers, same set as the RTL pipeline
  int m_p, m_d, m_integ, m_e1, m_e2, m_sl, m_sr;
  // inputs as applied in the current cycle
  bit cur_vld, cur_roff, cur_steer, cur_pwr;
  int cur_ptch, cur_ld;
  int e_ls, e_rs, e_lr, e_rr, e_ovr;  // expected outputs this cycle

  tb_clk_gen #(.period(8), .rst_cycles(10)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  balance_cntrl #(.fast_sim(1'b0)) i_balance_cntrl (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch), .ld_cell_diff(ld_cell_diff),
    .rider_off(rider_off), .en_steer(en_steer), .pwr_up(pwr_up),
    .lft_spd(lft_spd), .lft_rev(lft_rev), .rght_spd(rght_spd), .rght_rev(rght_rev),
    .ovr_spd(ovr_spd)
  );

  ////////////////////
  // model helpers
  ////////////////////
  function automatic int wrap_bits(input int v, input int w);
    int h;
    h = 1 << (w - 1);
    return ((v + h) & ((1 << w) - 1)) - h;  // two's complement wrap to w bits
  endfunction

  function automatic int clip(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  function automatic int shape_torque(input int t);
    int mag;
    mag = (t < 0) ? -t : t;
    if (mag >= int'(LOW_TORQUE_BAND))  // min duty pushed out with the sign
      return (t < 0) ? wrap_bits(t - int'(MIN_DUTY), 16) : wrap_bits(t + int'(MIN_DUTY), 16);
    return wrap_bits(int'(GAIN_MULTIPLIER) * t, 16);
  endfunction

  function automatic int speed_of(input int s, input bit pwr);
    int mag;
    mag = (s < 0) ? -s : s;
    return pwr ? clip(mag, 0, 2047) : 0;
  endfunction

  // one clock edge of the model, from the inputs held before the edge
  task automatic model_update();
    int err, diff, pid, ofs, sum;
    err  = clip(cur_ptch, -512, 511);
    pid  = wrap_bits(m_p + m_d + (cur_pwr ? (m_integ >>> 6) : 0), 16);
    ofs  = cur_ld >>> 3;
    m_sl = shape_torque(cur_steer ? wrap_bits(pid - ofs, 16) : pid);
    m_sr = shape_torque(cur_steer ? wrap_bits(pid + ofs, 16) : pid);
    diff = wrap_bits(err - m_e2, 10);  // error difference stays 10 bits wide
    m_p  = int'(P_COEFF) * err;
    m_d  = int'(D_COEFF) * clip(diff, -64, 63);
    if (cur_roff) begin
      m_integ = 0;
    end else if (cur_vld) begin
      sum = m_integ + err;
      if (sum >= -131072 && sum <= 131071) m_integ = sum;  // freeze on overflow
    end
    if (cur_vld) begin
      m_e2 = m_e1;
      m_e1 = err;
    end
  endtask

  ////////////////////
  // checking
  ////////////////////
  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("error %s: got %h expected %h at %0t", name, act, exp, $time);
    end
  endtask

  // clocks the model, drives new inputs just after the edge and checks mid-cycle
  // kind 0 is quiet, 1 random, 2 large positive pitch every cycle
  task automatic do_cycle(input bit pwr, input bit steer, input bit roff, input int kind);
    @(posedge clk);
    model_update();
    #1;
    cur_pwr   = pwr;
    cur_steer = steer;
    cur_roff  = roff;
    if (kind == 0) begin
      cur_vld  = 0;
      cur_ptch = 0;
      cur_ld   = 0;
    end else if (kind == 2) begin
      cur_vld  = 1;
      cur_ptch = 4000 + int'($urandom_range(8000, 0));
      cur_ld   = 0;
    end else begin
      cur_vld = ($urandom_range(3, 0) == 0);  // about one in four
      if ($urandom_range(7, 0) == 0) cur_ptch = wrap_bits(int'($urandom), 16);
      else cur_ptch = int'($urandom_range(1200, 0)) - 600;  // mostly small
      cur_ld = wrap_bits(int'($urandom), 12);
    end
    vld          = cur_vld;
    ptch         = cur_ptch;
    ld_cell_diff = cur_ld;
    rider_off    = cur_roff;
    en_steer     = cur_steer;
    pwr_up       = cur_pwr;
    @(negedge clk);  // outputs settled mid-cycle
    e_ls  = speed_of(m_sl, cur_pwr);
    e_rs  = speed_of(m_sr, cur_pwr);
    e_lr  = (m_sl < 0);
    e_rr  = (m_sr < 0);
    e_ovr = (e_ls > 1536) || (e_rs > 1536);
    check_val("lft_spd", lft_spd, e_ls);
    check_val("lft_rev", lft_rev, e_lr);
    check_val("rght_spd", rght_spd, e_rs);
    check_val("rght_rev", rght_rev, e_rr);
    check_val("ovr_spd", ovr_spd, e_ovr);
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("test %s done: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
  endtask

  ////////////////////
  // watchdog
  ////////////////////
  initial begin
    #200000;
    $display("timeout: simulation ran past its time limit");
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    int c0, e0, n;
    vld          = 0;
    ptch         = '0;
    ld_cell_diff = '0;
    rider_off    = 0;
    en_steer     = 0;
    pwr_up       = 0;
    cur_vld   = 0;
    cur_roff  = 0;
    cur_steer = 0;
    cur_pwr   = 0;
    cur_ptch  = 0;
    cur_ld    = 0;
    m_p     = 0;
    m_d     = 0;
    m_integ = 0;
    m_e1    = 0;
    m_e2    = 0;
    m_sl    = 0;
    m_sr    = 0;
    void'($urandom(32'h3eb1_8ad3));
    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin  // reset release, bounded
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      c0 = n_checks;
      e0 = n_errors;
      repeat (4) begin
        do_cycle(0, 0, 0, 0);
        check_val("lft_spd", lft_spd, 0);
        check_val("rght_spd", rght_spd, 0);
        check_val("lft_rev", lft_rev, 0);
        check_val("rght_rev", rght_rev, 0);
        check_val("ovr_spd", ovr_spd, 0);
      end
      report_test("reset", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      repeat (200) begin
        do_cycle(0, 0, 0, 1);
        check_val("lft_spd", lft_spd, 0);
        check_val("rght_spd", rght_spd, 0);
      end
      repeat (50) do_cycle(1, 0, 0, 1);  // integrator kept tracking meanwhile
      report_test("power gating", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      repeat (2000) begin
        do_cycle(1, 0, 0, 1);
        check_val("rght_spd", rght_spd, e_ls);  // no steering, wheels equal
        check_val("rght_rev", rght_rev, e_lr);
      end
      report_test("balance", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      repeat (2000) do_cycle(1, 1, 0, 1);
      report_test("steering", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      repeat (100) do_cycle(1, 1, 0, 1);
      repeat (30) do_cycle(1, 1, 1, 1);
      check_val("integ", i_balance_cntrl.u_ptch_pid.integ, 0);  // cleared by rider_off
      repeat (100) do_cycle(1, 1, 0, 1);
      report_test("rider off", c0, e0);

      c0 = n_checks;
      e0 = n_errors;
      repeat (400) do_cycle(1, 0, 0, 2);  // drives the integrator to its limit
      repeat (50) do_cycle(1, 0, 0, 2);
      check_val("lft_spd", lft_spd, 2047);
      check_val("rght_spd", rght_spd, 2047);
      check_val("ovr_spd", ovr_spd, 1);
      report_test("saturation", c0, e0);

      $display("summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- all.f
hw/balance_pkg.sv
hw/motor_cmd_if.sv
hw/ptch_pid.sv
hw/torque_shaper.sv
hw/wheel_drive.sv
hw/balance_cntrl.sv
tb/tb_clk_gen.sv
tb/balance_chk.sv
tb/balance_tb.sv

//--- Bender.yml
package:
  name: balance_cntrl

sources:
  - hw/balance_pkg.sv
  - hw/motor_cmd_if.sv
  - hw/ptch_pid.sv
  - hw/torque_shaper.sv
  - hw/wheel_drive.sv
  - hw/balance_cntrl.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/balance_chk.sv
      - tb/balance_tb.sv
